//--- Bender.yml
package:
  name: elevator_floor_controller

sources:
  - files:
      - rtl/elevator_pkg.sv
      - rtl/request_latch.sv
      - rtl/request_queue.sv
      - rtl/car_control.sv
      - rtl/elevator_floor_controller.sv
  - target: test
    files:
      - testbench/elevator_checker.sv
      - testbench/elevator_assert.sv
      - testbench/tb_elevator.sv

//--- list.f
rtl/elevator_pkg.sv
rtl/request_latch.sv
rtl/request_queue.sv
rtl/car_control.sv
rtl/elevator_floor_controller.sv
testbench/elevator_checker.sv
testbench/elevator_assert.sv
testbench/tb_elevator.sv

//--- rtl/car_control.sv
////////////////////////////////////////
// Car control
// Dispatch FSM, car command, door permits
////////////////////////////////////////

`timescale 1ns/1ns

module car_control
    import elevator_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  button_bank_t buttons,
    input  car_status_t  car_status,
    input  floor_t       head_floor,
    input  logic         not_empty,
    output logic         pop,
    output car_command_t car_command,
    output logic         arrive,
    output floor_t       arrive_floor,
    output door_permit_t door_permit
);

    dispatch_state_e state;
    floor_t          target;
    logic            dir_up;
    logic            run_ok;
    logic            head_here;
    logic            at_target;

    assign run_ok    = buttons.power && !buttons.emergency;
    assign head_here = (head_floor == car_status.current_floor);
    assign at_target = (target == car_status.current_floor);

    // Take the next request only with the car at rest
    assign pop = (state == DISP_IDLE) && not_empty && run_ok && !car_status.moving;

    ////////////////////////////////////////
    // Dispatch FSM
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= DISP_IDLE;
            target       <= '0;
            dir_up       <= 1'b0;
            arrive       <= 1'b0;
            arrive_floor <= '0;
        end else begin
            arrive <= 1'b0;
            case (state)
                DISP_IDLE: begin
                    if (pop) begin
                        target <= head_floor;
                        dir_up <= (head_floor > car_status.current_floor);
                        // Already there, retire without moving
                        if (head_here) begin
                            arrive       <= 1'b1;
                            arrive_floor <= head_floor;
                        end else begin
                            state <= DISP_ISSUE;
                        end
                    end
                end
                DISP_ISSUE: begin
                    // Motion FSM has taken the command
                    if (car_status.moving) begin
                        state <= DISP_TRAVEL;
                    end
                end
                DISP_TRAVEL: begin
                    if (!car_status.moving) begin
                        if (at_target) begin
                            arrive       <= 1'b1;
                            arrive_floor <= target;
                            state        <= DISP_IDLE;
                        end else begin
                            // Stopped short, command again from here
                            dir_up <= (target > car_status.current_floor);
                            state  <= DISP_ISSUE;
                        end
                    end
                end
                default: begin
                    state <= DISP_IDLE;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Car command
    ////////////////////////////////////////

    // Activate drops at once on power loss, emergency or motion
    always_comb begin
        car_command.target_floor = target;
        car_command.dir_up       = dir_up;
        car_command.activate     = (state == DISP_ISSUE) && run_ok && !car_status.moving;
    end

    ////////////////////////////////////////
    // Door permits
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_permit <= '0;
        end else begin
            door_permit.open_allowed  <= buttons.door_open && buttons.power
                                         && !car_status.moving;
            door_permit.close_allowed <= buttons.door_close && buttons.power
                                         && !car_status.moving;
        end
    end

endmodule

//--- rtl/elevator_floor_controller.sv
////////////////////////////////////////
// Elevator floor controller top
// Button latch, request FIFO and car control
////////////////////////////////////////

`timescale 1ns/1ns

module elevator_floor_controller
    import elevator_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  button_bank_t buttons,
    input  car_status_t  car_status,
    output car_command_t car_command,
    output door_permit_t door_permit,
    output floor_mask_t  call_lights,
    output floor_mask_t  panel_lights
);

    // Latch to queue
    logic   req_valid;
    floor_t req_floor;

    // Queue to car control
    floor_t head_floor;
    logic   not_empty;
    logic   pop;

    // Car control back to the latch
    logic   arrive;
    floor_t arrive_floor;

    request_latch i_request_latch (
        .clock         (clock),
        .reset_n       (reset_n),
        .buttons       (buttons),
        .current_floor (car_status.current_floor),
        .arrive        (arrive),
        .arrive_floor  (arrive_floor),
        .req_valid     (req_valid),
        .req_floor     (req_floor),
        .call_lights   (call_lights),
        .panel_lights  (panel_lights)
    );

    request_queue i_request_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (req_valid),
        .push_floor (req_floor),
        .pop        (pop),
        .head_floor (head_floor),
        .not_empty  (not_empty)
    );

    car_control i_car_control (
        .clock        (clock),
        .reset_n      (reset_n),
        .buttons      (buttons),
        .car_status   (car_status),
        .head_floor   (head_floor),
        .not_empty    (not_empty),
        .pop          (pop),
        .car_command  (car_command),
        .arrive       (arrive),
        .arrive_floor (arrive_floor),
        .door_permit  (door_permit)
    );

endmodule

//--- rtl/elevator_pkg.sv
////////////////////////////////////////
// Elevator floor controller package
// Floor types, port structs, dispatch states
////////////////////////////////////////

package elevator_pkg;

    // Building size and request storage
    localparam int NUM_FLOORS  = 11;
    localparam int QUEUE_DEPTH = 32;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

    // Floor index, 0 is the first floor
    typedef logic [3:0] floor_t;

    // One bit per floor, bit 0 is the first floor
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // Operator inputs, all active high
    typedef struct packed {
        floor_mask_t call;
        floor_mask_t panel;
        logic        door_open;
        logic        door_close;
        logic        emergency;
        logic        power;
    } button_bank_t;

    // Reported by the motion FSM
    typedef struct packed {
        floor_t current_floor;
        logic   moving;
    } car_status_t;

    // Sent to the motion FSM
    typedef struct packed {
        floor_t target_floor;
        logic   dir_up;
        logic   activate;
    } car_command_t;

    typedef struct packed {
        logic open_allowed;
        logic close_allowed;
    } door_permit_t;

    typedef enum logic [1:0] {
        DISP_IDLE,
        DISP_ISSUE,
        DISP_TRAVEL
    } dispatch_state_e;

endpackage

//--- rtl/request_latch.sv
////////////////////////////////////////
// Request latch
// Accepts button presses, keeps the lights
////////////////////////////////////////

`timescale 1ns/1ns

module request_latch
    import elevator_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  button_bank_t buttons,
    input  floor_t       current_floor,
    input  logic         arrive,
    input  floor_t       arrive_floor,
    output logic         req_valid,
    output floor_t       req_floor,
    output floor_mask_t  call_lights,
    output floor_mask_t  panel_lights
);

    logic        accept_ok;
    floor_mask_t here_mask;
    floor_mask_t clear_mask;
    floor_mask_t panel_eligible;
    floor_mask_t call_eligible;
    floor_mask_t panel_set;
    floor_mask_t call_set;
    logic        found;
    floor_t      found_floor;

    // Presses only count while powered and not in emergency
    assign accept_ok = buttons.power && !buttons.emergency;

    assign here_mask  = floor_mask_t'(1) << current_floor;
    assign clear_mask = arrive ? (floor_mask_t'(1) << arrive_floor) : '0;

    // A lit button or the floor we are at cannot be requested again
    assign panel_eligible = accept_ok ? (buttons.panel & ~panel_lights & ~here_mask) : '0;
    assign call_eligible  = accept_ok ? (buttons.call & ~call_lights & ~here_mask) : '0;

    ////////////////////////////////////////
    // Fixed priority pick
    ////////////////////////////////////////

    // Panel bank first, then call bank, lowest floor wins in each
    always_comb begin
        found       = 1'b0;
        found_floor = '0;
        panel_set   = '0;
        call_set    = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (!found && panel_eligible[i]) begin
                found        = 1'b1;
                found_floor  = floor_t'(i);
                panel_set[i] = 1'b1;
            end
        end
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (!found && call_eligible[i]) begin
                found       = 1'b1;
                found_floor = floor_t'(i);
                call_set[i] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Lights and request strobe
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
            req_valid    <= 1'b0;
        end else begin
            // Arrival clears both banks for that floor
            call_lights  <= (call_lights & ~clear_mask) | call_set;
            panel_lights <= (panel_lights & ~clear_mask) | panel_set;
            req_valid    <= found;
        end
    end

    always_ff @(posedge clock) begin
        if (found) begin
            req_floor <= found_floor;
        end
    end

endmodule

//--- rtl/request_queue.sv
////////////////////////////////////////
// Request queue
// Circular FIFO of accepted floor requests
////////////////////////////////////////

`timescale 1ns/1ns

module request_queue
    import elevator_pkg::*;
(
    input  logic   clock,
    input  logic   reset_n,
    input  logic   push,
    input  floor_t push_floor,
    input  logic   pop,
    output floor_t head_floor,
    output logic   not_empty
);

    floor_t                 mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= push_floor;
        end
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Occupancy
    ////////////////////////////////////////

    // Simultaneous push and pop leave the count alone
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign not_empty  = (count != '0);
    assign head_floor = mem[rd_ptr];

endmodule

//--- testbench/elevator_assert.sv
////////////////////////////////////////
// Elevator assertions
// Queue safety and arrival position
////////////////////////////////////////

`timescale 1ns/1ns

module elevator_assert
    import elevator_pkg::*;
(
    input logic                 clock,
    input logic                 reset_n,
    input logic                 push,
    input logic                 pop,
    input logic                 not_empty,
    input logic [QUEUE_PTR_W:0] count,
    input logic                 arrive,
    input floor_t               arrive_floor,
    input floor_t               current_floor,
    input logic                 moving
);

    // Number of failed assertions
    int fail_count = 0;

    no_overflow: assert property (@(posedge clock) disable iff (!reset_n)
        push |-> (count != QUEUE_DEPTH))
        else begin
            fail_count++;
            $error("Push into a full request queue");
        end

    no_underflow: assert property (@(posedge clock) disable iff (!reset_n)
        pop |-> not_empty)
        else begin
            fail_count++;
            $error("Pop from an empty request queue");
        end

    // Arrival only with the car standing at that floor
    arrive_at_floor: assert property (@(posedge clock) disable iff (!reset_n)
        arrive |-> (current_floor == arrive_floor) && !moving)
        else begin
            fail_count++;
            $error("Arrive signalled away from the arrival floor or while moving");
        end

endmodule

bind request_queue elevator_assert i_queue_assert (
    .clock         (clock),
    .reset_n       (reset_n),
    .push          (push),
    .pop           (pop),
    .not_empty     (not_empty),
    .count         (count),
    .arrive        (1'b0),
    .arrive_floor  ('0),
    .current_floor ('0),
    .moving        (1'b0)
);

bind car_control elevator_assert i_car_assert (
    .clock         (clock),
    .reset_n       (reset_n),
    .push          (1'b0),
    .pop           (1'b0),
    .not_empty     (1'b0),
    .count         ('0),
    .arrive        (arrive),
    .arrive_floor  (arrive_floor),
    .current_floor (car_status.current_floor),
    .moving        (car_status.moving)
);

//--- testbench/elevator_checker.sv
////////////////////////////////////////
// Elevator checker
// Reference model and compare of DUT ports
////////////////////////////////////////

`timescale 1ns/1ns

module elevator_checker
    import elevator_pkg::*;
(
    input  logic         clock,
    input  logic         reset_n,
    input  button_bank_t buttons,
    input  car_status_t  car_status,
    input  car_command_t car_command,
    input  door_permit_t door_permit,
    input  floor_mask_t  call_lights,
    input  floor_mask_t  panel_lights,
    output int           error_count
);

    floor_t       exp_q[$];
    floor_mask_t  exp_call;
    floor_mask_t  exp_panel;
    door_permit_t exp_door;
    logic         push_pend;
    floor_t       push_floor;
    logic         arr_pend;
    floor_t       arr_floor;
    int           m_state;
    floor_t       m_target;

    // Accepted press as {found, from call bank, floor}
    function automatic logic [5:0] pick_request(floor_mask_t call, floor_mask_t panel,
                                                floor_mask_t call_lit, floor_mask_t panel_lit,
                                                floor_t here, logic ok);
        if (!ok) begin
            return '0;
        end
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (panel[i] && !panel_lit[i] && i != here) begin
                return {1'b1, 1'b0, 4'(i)};
            end
        end
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (call[i] && !call_lit[i] && i != here) begin
                return {1'b1, 1'b1, 4'(i)};
            end
        end
        return '0;
    endfunction

    task automatic report_mismatch(string name, int expected, int actual);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        error_count++;
    endtask

    initial begin
        error_count = 0;
    end

    always @(posedge clock) begin : compare
        logic [5:0]  pick;
        floor_mask_t clr;
        floor_t      here;
        logic        run_ok;
        logic        exp_act;
        here   = car_status.current_floor;
        run_ok = buttons.power && !buttons.emergency;
        if (!reset_n) begin
            exp_q.delete();
            exp_call  = '0;
            exp_panel = '0;
            exp_door  = '0;
            push_pend = 1'b0;
            arr_pend  = 1'b0;
            m_state   = 0;
        end else begin
            // Registered outputs against last edge's expectation
            if (call_lights !== exp_call)
                report_mismatch("call_lights", exp_call, call_lights);
            if (panel_lights !== exp_panel)
                report_mismatch("panel_lights", exp_panel, panel_lights);
            if (door_permit !== exp_door)
                report_mismatch("door_permit", exp_door, door_permit);

            // Command checks, activate only while issuing to a stopped powered car
            exp_act = (m_state == 1) && run_ok && !car_status.moving;
            if (car_command.activate !== exp_act)
                report_mismatch("activate", exp_act, car_command.activate);
            if (car_command.activate && exp_act) begin
                if (car_command.target_floor !== m_target)
                    report_mismatch("target_floor", m_target, car_command.target_floor);
                if (car_command.dir_up !== (m_target > here))
                    report_mismatch("dir_up", m_target > here, car_command.dir_up);
            end

            // Next lights
            clr  = arr_pend ? (floor_mask_t'(1) << arr_floor) : '0;
            pick = pick_request(buttons.call, buttons.panel, exp_call, exp_panel,
                                here, run_ok);
            exp_call  = exp_call & ~clr;
            exp_panel = exp_panel & ~clr;
            if (pick[5] && pick[4])
                exp_call[pick[3:0]] = 1'b1;
            if (pick[5] && !pick[4])
                exp_panel[pick[3:0]] = 1'b1;
            exp_door.open_allowed  = buttons.door_open && buttons.power && !car_status.moving;
            exp_door.close_allowed = buttons.door_close && buttons.power && !car_status.moving;

            // Dispatch model
            arr_pend = 1'b0;
            case (m_state)
                0: begin
                    if (exp_q.size() > 0 && run_ok && !car_status.moving) begin
                        m_target = exp_q.pop_front();
                        if (m_target == here) begin
                            arr_pend  = 1'b1;
                            arr_floor = m_target;
                        end else begin
                            m_state = 1;
                        end
                    end
                end
                1: if (car_status.moving) m_state = 2;
                default: begin
                    if (!car_status.moving) begin
                        if (m_target == here) begin
                            arr_pend  = 1'b1;
                            arr_floor = m_target;
                            m_state   = 0;
                        end else begin
                            m_state = 1;
                        end
                    end
                end
            endcase

            // Accepted press reaches the queue one cycle later
            if (push_pend)
                exp_q.push_back(push_floor);
            push_pend  = pick[5];
            push_floor = pick[3:0];
        end
    end

endmodule

//--- testbench/tb_elevator.sv
////////////////////////////////////////
// Elevator testbench top
// Clock, car motion model, stimulus
////////////////////////////////////////

`timescale 1ns/1ns

module tb_elevator;
    import elevator_pkg::*;

    localparam int NUM_PHASES   = 4;
    localparam int PHASE_CYCLES = 2 * NUM_FLOORS * (10 * 4 + 10);
    localparam int LIMIT_CYCLES = NUM_PHASES * PHASE_CYCLES;

    logic         clock;
    logic         reset_n;
    button_bank_t buttons;
    car_status_t  car_status;
    car_command_t car_command;
    door_permit_t door_permit;
    floor_mask_t  call_lights;
    floor_mask_t  panel_lights;
    int           error_count;
    int           assert_errors;
    floor_t       goal;
    int           step_count;

    elevator_floor_controller i_dut (.*);

    elevator_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Car motion, one floor every 4 cycles
    always @(posedge clock) begin : motion
        logic   act;
        logic   rst_n;
        floor_t tgt;
        act   = car_command.activate;
        tgt   = car_command.target_floor;
        rst_n = reset_n;
        #1;
        if (!rst_n) begin
            car_status <= '0;
        end else if (!car_status.moving && act) begin
            goal       = tgt;
            step_count = 0;
            car_status.moving <= 1'b1;
        end else if (car_status.moving) begin
            step_count++;
            if (step_count == 4) begin
                step_count = 0;
                if (goal > car_status.current_floor) begin
                    car_status.current_floor <= car_status.current_floor + 1'b1;
                    car_status.moving <= (car_status.current_floor + 1'b1 != goal);
                end else begin
                    car_status.current_floor <= car_status.current_floor - 1'b1;
                    car_status.moving <= (car_status.current_floor - 1'b1 != goal);
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic press(logic on_panel, int floor, int cycles);
        if (on_panel)
            buttons.panel[floor] = 1'b1;
        else
            buttons.call[floor] = 1'b1;
        repeat (cycles) next_cycle();
        buttons.panel = '0;
        buttons.call  = '0;
    endtask

    task automatic wait_idle();
        do begin
            next_cycle();
        end while (call_lights != '0 || panel_lights != '0 || car_status.moving
                   || car_command.activate);
        repeat (4) next_cycle();
    endtask

    initial begin
        void'($urandom(94));
        buttons = '0;
        buttons.power = 1'b1;
        car_status = '0;
        reset_n = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset_n = 1'b1;

        // Directed presses, floor 0 is the current one
        press(1'b1, 5, 2);
        press(1'b0, 2, 1);
        press(1'b1, 0, 2);
        press(1'b0, 5, 1);
        wait_idle();

        // Random bursts
        repeat (6) begin
            buttons.panel = floor_mask_t'($urandom & $urandom);
            buttons.call  = floor_mask_t'($urandom & $urandom);
            repeat ($urandom_range(1, 3)) next_cycle();
            buttons.panel = '0;
            buttons.call  = '0;
            repeat ($urandom_range(0, 20)) next_cycle();
        end
        wait_idle();

        // Emergency and power windows
        press(1'b1, 9, 1);
        next_cycle();
        buttons.emergency = 1'b1;
        press(1'b0, 3, 8);
        buttons.emergency = 1'b0;
        buttons.power = 1'b0;
        press(1'b1, 1, 4);
        buttons.power = 1'b1;
        wait_idle();

        // Door buttons with the car both stopped and moving
        press(1'b1, 4, 1);
        repeat (40) begin
            buttons.door_open  = 1'($urandom_range(0, 1));
            buttons.door_close = 1'($urandom_range(0, 1));
            buttons.power      = ($urandom_range(0, 7) != 0);
            next_cycle();
        end
        buttons.door_open  = 1'b0;
        buttons.door_close = 1'b0;
        buttons.power      = 1'b1;
        wait_idle();

        assert_errors = i_dut.i_request_queue.i_queue_assert.fail_count
                        + i_dut.i_car_control.i_car_assert.fail_count;
        $display("Run complete with %0d check errors and %0d assertion failures",
                 error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog over all phases
    initial begin
        repeat (LIMIT_CYCLES + 20) @(posedge clock);
        $display("Watchdog timeout, the run did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule
